// File: branch_predictor_top.f
src/bp_pkg.sv
src/priority_encoder.sv
src/branch_target_buffer.sv
src/fetch_pc_unit.sv
src/bp_csr.sv
src/branch_predictor_top.sv
sim/branch_predictor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f branch_predictor_top.f \
  --top-module branch_predictor_tb \
  -o branch_predictor_tb

output=$(./obj_dir/branch_predictor_tb)
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
  exit 0
fi
exit 1

// File: sim/branch_predictor_tb.sv
`default_nettype none

module branch_predictor_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bp_pkg::*;

  localparam int  BTB_ENTRIES  = 8;
  localparam pc_t RESET_PC     = 32'h0000_1000;
  localparam int  CLK_PERIOD   = 20;
  localparam int  RESET_CYCLES = 16;
  // replacement and flush tests grow with the table size.
  localparam int  TEST_CYCLES  = RESET_CYCLES + 120 + 10 * BTB_ENTRIES;
  localparam resolve_t NO_RESOLVE = '0;

  logic                      clk;
  logic                      reset;
  logic                      fetch_enable;
  logic                      csr_write;
  logic [CSR_ADDR_WIDTH-1:0] csr_addr;
  logic [31:0]               csr_wdata;
  logic [31:0]               csr_rdata;
  resolve_t                  resolve;
  pc_t                       fetch_pc;

  // reference model of table, pc and csr state.
  pc_t         m_key    [BTB_ENTRIES];
  pc_t         m_target [BTB_ENTRIES];
  logic        m_valid  [BTB_ENTRIES];
  int          m_count  [BTB_ENTRIES]; // 0 strong not taken up to 3 strong taken.
  int          m_ptr;
  pc_t         m_pc;
  logic        m_enable;
  logic [31:0] m_lookups;
  logic [31:0] m_predicted;

  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  pc_t branch_pc;
  pc_t branch_target;
  pc_t alloc_pc     [BTB_ENTRIES+1];
  pc_t alloc_target [BTB_ENTRIES+1];

  branch_predictor_top #(
    .BTB_ENTRIES(BTB_ENTRIES),
    .RESET_PC   (RESET_PC)
  ) branch_predictor_top_inst (
    .clk         (clk),
    .reset       (reset),
    .fetch_enable(fetch_enable),
    .csr_write   (csr_write),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .csr_rdata   (csr_rdata),
    .resolve     (resolve),
    .fetch_pc    (fetch_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function pc_t random_pc();
    logic [31:0] r;
    r = next_random();
    return {r[15:0], r[31:18], 2'b00}; // better bits moved low.
  endfunction

  function int find_entry(input pc_t pc);
    int found;
    found = -1;
    for (int i = BTB_ENTRIES - 1; i >= 0; i--) begin
      if (m_valid[i] && m_key[i] == pc) found = i;
    end
    return found;
  endfunction

  function resolve_t make_resolve(input pc_t pc, input pc_t target, input logic taken,
                                  input logic redirect, input pc_t next_pc);
    resolve_t rs;
    rs.valid    = 1'b1;
    rs.pc       = pc;
    rs.target   = target;
    rs.taken    = taken;
    rs.redirect = redirect;
    rs.next_pc  = next_pc;
    return rs;
  endfunction

  task reset_model();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_key[i]    = '0;
      m_target[i] = '0;
      m_valid[i]  = 1'b0;
      m_count[i]  = 0;
    end
    m_ptr       = 0;
    m_pc        = RESET_PC;
    m_enable    = 1'b1;
    m_lookups   = '0;
    m_predicted = '0;
  endtask

  // state after the edge that ends this cycle.
  task update_model(input logic fe, input resolve_t rs, input logic wr,
                    input logic [CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] wdata);
    int   li;
    int   ui;
    logic predicted;
    li        = find_entry(m_pc);
    predicted = 1'b0;
    if (m_enable && li >= 0) predicted = (m_count[li] >= 2);
    if (fe) begin
      m_lookups = m_lookups + 1;
      if (predicted) m_predicted = m_predicted + 1;
    end
    if (rs.valid && rs.redirect) begin
      m_pc = rs.next_pc;
    end else if (fe) begin
      m_pc = predicted ? m_target[li] : m_pc + 4;
    end
    if (wr && addr == 2'd1) begin
      for (int i = 0; i < BTB_ENTRIES; i++) m_valid[i] = 1'b0;
      m_ptr = 0;
    end else if (rs.valid) begin
      ui = find_entry(rs.pc);
      if (ui >= 0) begin
        if (rs.taken) m_target[ui] = rs.target;
        if (rs.taken && m_count[ui] < 3) m_count[ui] = m_count[ui] + 1;
        if (!rs.taken && m_count[ui] > 0) m_count[ui] = m_count[ui] - 1;
      end else begin
        m_key[m_ptr]    = rs.pc;
        m_target[m_ptr] = rs.target;
        m_valid[m_ptr]  = 1'b1;
        m_count[m_ptr]  = rs.taken ? 3 : 0;
        m_ptr           = (m_ptr + 1) % BTB_ENTRIES;
      end
    end
    if (wr && addr == 2'd0) m_enable = wdata[0];
  endtask

  task check_pc(input string name, input pc_t actual, input pc_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task check_data(input string name, input logic [31:0] actual, input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task do_cycle(input logic fe, input resolve_t rs, input logic wr,
                input logic [CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    fetch_enable <= fe;
    resolve      <= rs;
    csr_write    <= wr;
    csr_addr     <= addr;
    csr_wdata    <= wdata;
    update_model(fe, rs, wr, addr, wdata);
  endtask

  // one idle cycle commits the last one before the mid-cycle sample.
  task settle();
    do_cycle(1'b0, NO_RESOLVE, 1'b0, 2'd0, 32'd0);
    @(negedge clk);
  endtask

  task read_csr(input logic [CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] expected);
    do_cycle(1'b0, NO_RESOLVE, 1'b0, addr, 32'd0);
    @(negedge clk);
    check_data($sformatf("csr_rdata[%0d]", addr), csr_rdata, expected);
  endtask

  task write_csr(input logic [CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    do_cycle(1'b0, NO_RESOLVE, 1'b1, addr, data);
    settle();
  endtask

  task step_fetch(input int n);
    repeat (n) begin
      do_cycle(1'b1, NO_RESOLVE, 1'b0, 2'd0, 32'd0);
      settle();
      check_pc("fetch_pc", fetch_pc, m_pc);
    end
  endtask

  task resolve_and_check(input resolve_t rs);
    do_cycle(1'b0, rs, 1'b0, 2'd0, 32'd0);
    settle();
    check_pc("fetch_pc", fetch_pc, m_pc);
  endtask

  // redirect wins over fetch_enable in the same cycle.
  task jump_and_step(input pc_t anchor, input pc_t anchor_target, input logic anchor_taken,
                     input pc_t dest);
    do_cycle(1'b1, make_resolve(anchor, anchor_target, anchor_taken, 1'b1, dest),
             1'b0, 2'd0, 32'd0);
    settle();
    check_pc("fetch_pc after redirect", fetch_pc, dest);
    step_fetch(1);
  endtask

  task test_reset_sequential();
    settle();
    check_pc("fetch_pc", fetch_pc, RESET_PC);
    read_csr(2'd0, 32'd1);
    read_csr(2'd2, 32'd0);
    read_csr(2'd3, 32'd0);
    repeat (3) do_cycle(1'b1, NO_RESOLVE, 1'b0, 2'd0, 32'd0);
    settle();
    check_pc("fetch_pc", fetch_pc, RESET_PC + 32'd12);
    repeat (2) do_cycle(1'b0, NO_RESOLVE, 1'b0, 2'd0, 32'd0);
    settle();
    check_pc("fetch_pc held", fetch_pc, RESET_PC + 32'd12);
    for (int i = 0; i < 4; i++) begin
      do_cycle(i % 2 == 0, NO_RESOLVE, 1'b0, 2'd0, 32'd0);
    end
    settle();
    check_pc("fetch_pc", fetch_pc, m_pc);
  endtask

  task test_alloc_predict();
    branch_pc     = RESET_PC + 32'd8;
    branch_target = random_pc();
    resolve_and_check(make_resolve(branch_pc, branch_target, 1'b1, 1'b1, RESET_PC));
    step_fetch(3);
    check_pc("predicted target", fetch_pc, branch_target);
    step_fetch(1); // target itself is not a branch.
    check_pc("unknown pc", fetch_pc, branch_target + 32'd4);
  endtask

  task test_hysteresis();
    resolve_and_check(make_resolve(branch_pc, branch_target, 1'b0, 1'b1, branch_pc));
    step_fetch(1);
    check_pc("weak taken target", fetch_pc, branch_target);
    resolve_and_check(make_resolve(branch_pc, branch_target, 1'b0, 1'b1, branch_pc));
    step_fetch(1);
    check_pc("weak not taken pc", fetch_pc, branch_pc + 32'd4);
    resolve_and_check(make_resolve(branch_pc, branch_target, 1'b1, 1'b0, '0));
    resolve_and_check(make_resolve(branch_pc, branch_target, 1'b1, 1'b1, branch_pc));
    step_fetch(1);
    check_pc("restored target", fetch_pc, branch_target);
  endtask

  task test_replacement();
    for (int i = 0; i <= BTB_ENTRIES; i++) begin
      do begin
        alloc_pc[i] = random_pc();
      end while (find_entry(alloc_pc[i]) >= 0);
      alloc_target[i] = random_pc();
      do_cycle(1'b0, make_resolve(alloc_pc[i], alloc_target[i], 1'b1, 1'b0, '0),
               1'b0, 2'd0, 32'd0);
    end
    settle();
    for (int i = 0; i <= BTB_ENTRIES; i++) begin
      jump_and_step(alloc_pc[BTB_ENTRIES], alloc_target[BTB_ENTRIES], 1'b1, alloc_pc[i]);
      check_pc("after replacement", fetch_pc,
               (i == 0) ? alloc_pc[i] + 32'd4 : alloc_target[i]);
    end
  endtask

  task test_csr();
    pc_t anchor;
    pc_t anchor_target;
    anchor        = alloc_pc[BTB_ENTRIES];
    anchor_target = alloc_target[BTB_ENTRIES];
    write_csr(2'd0, 32'd0);
    read_csr(2'd0, 32'd0);
    jump_and_step(anchor, anchor_target, 1'b1, anchor);
    check_pc("disabled lookup", fetch_pc, anchor + 32'd4);
    write_csr(2'd0, 32'd1);
    jump_and_step(anchor, anchor_target, 1'b1, anchor);
    check_pc("enabled lookup", fetch_pc, anchor_target);
    // flush beats an allocation in the same cycle.
    do_cycle(1'b0, make_resolve(alloc_pc[0], alloc_target[0], 1'b1, 1'b0, '0),
             1'b1, 2'd1, 32'hffff_ffff);
    settle();
    read_csr(2'd1, 32'd0);
    // anchor comes back as not taken, so nothing may predict.
    for (int i = 0; i <= BTB_ENTRIES; i++) begin
      jump_and_step(anchor, anchor_target, 1'b0, alloc_pc[i]);
      check_pc("after flush", fetch_pc, alloc_pc[i] + 32'd4);
    end
    read_csr(2'd2, m_lookups);
    read_csr(2'd3, m_predicted);
  endtask

  initial begin
    reset        = 1'b1;
    fetch_enable = 1'b0;
    csr_write    = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    resolve      = NO_RESOLVE;
    lcg_state    = 32'd6913;
    errors       = 0;
    checks       = 0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    test_reset_sequential();
    test_alloc_predict();
    test_hysteresis();
    test_replacement();
    test_csr();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/branch_predictor_top.sv
`default_nettype none

module branch_predictor_top #(
  parameter int          BTB_ENTRIES = 8,
  parameter bp_pkg::pc_t RESET_PC    = 32'h0000_1000
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              fetch_enable,
  input  logic                              csr_write,
  input  logic [bp_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
  input  logic [31:0]                       csr_wdata,
  output logic [31:0]                       csr_rdata,
  input  bp_pkg::resolve_t                  resolve,
  output bp_pkg::pc_t                       fetch_pc
);

  import bp_pkg::*;

  logic    lookup_enable;
  logic    flush;
  lookup_t lookup;

  bp_csr u_csr (
    .clk          (clk),
    .reset        (reset),
    .fetch_enable (fetch_enable),
    .csr_write    (csr_write),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .lookup       (lookup),
    .lookup_enable(lookup_enable),
    .flush        (flush)
  );

  branch_target_buffer #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .clk          (clk),
    .reset        (reset),
    .lookup_enable(lookup_enable),
    .flush        (flush),
    .pc           (fetch_pc),
    .lookup       (lookup),
    .resolve      (resolve)
  );

  fetch_pc_unit #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .reset       (reset),
    .fetch_enable(fetch_enable),
    .lookup      (lookup),
    .resolve     (resolve),
    .fetch_pc    (fetch_pc)
  );

endmodule

`default_nettype wire

// File: src/bp_csr.sv
`default_nettype none

module bp_csr (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              fetch_enable,
  input  logic                              csr_write,
  input  logic [bp_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
  input  logic [31:0]                       csr_wdata,
  output logic [31:0]                       csr_rdata,
  input  bp_pkg::lookup_t                   lookup,
  output logic                              lookup_enable,
  output logic                              flush
);

  import bp_pkg::*;

  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_CTRL   = 2'd0;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_FLUSH  = 2'd1;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_LOOKUP = 2'd2;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_TAKEN  = 2'd3;

  logic        enable_q;
  logic [31:0] lookup_count;
  logic [31:0] taken_count;
  logic        predicted;

  assign lookup_enable = enable_q;

  // single-cycle pulse, lands on the buffer at the end of the write cycle.
  assign flush = csr_write && (csr_addr == ADDR_FLUSH);

  assign predicted = lookup.hit && lookup.predict_taken;

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q <= 1'b1;
    end else if (csr_write && csr_addr == ADDR_CTRL) begin
      enable_q <= csr_wdata[0];
    end
  end

  // statistics, free running and wrapping.
  always_ff @(posedge clk) begin
    if (reset) begin
      lookup_count <= '0;
      taken_count  <= '0;
    end else if (fetch_enable) begin
      lookup_count <= lookup_count + 1'b1;
      if (predicted) begin
        taken_count <= taken_count + 1'b1;
      end
    end
  end

  always_comb begin
    case (csr_addr)
      ADDR_CTRL:   csr_rdata = {31'd0, enable_q};
      ADDR_FLUSH:  csr_rdata = '0; // write-only.
      ADDR_LOOKUP: csr_rdata = lookup_count;
      ADDR_TAKEN:  csr_rdata = taken_count;
      default:     csr_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/fetch_pc_unit.sv
`default_nettype none

module fetch_pc_unit #(
  parameter bp_pkg::pc_t RESET_PC = 32'h0000_1000
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             fetch_enable,
  input  bp_pkg::lookup_t  lookup,
  input  bp_pkg::resolve_t resolve,
  output bp_pkg::pc_t      fetch_pc
);

  import bp_pkg::*;

  localparam pc_t PC_STEP = 4;

  pc_t seq_pc;
  pc_t predicted_pc;
  logic mispredict;

  assign seq_pc     = fetch_pc + PC_STEP;
  assign mispredict = resolve.valid && resolve.redirect;

  // predicted target only on a taken-half hit.
  assign predicted_pc = (lookup.hit && lookup.predict_taken) ? lookup.target : seq_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc <= RESET_PC;
    end else if (mispredict) begin
      fetch_pc <= resolve.next_pc; // execute overrides fetch.
    end else if (fetch_enable) begin
      fetch_pc <= predicted_pc;
    end
  end

endmodule

`default_nettype wire

// File: src/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer #(
  parameter int BTB_ENTRIES = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              lookup_enable,
  input  logic              flush,
  input  bp_pkg::pc_t       pc,
  output bp_pkg::lookup_t   lookup,
  input  bp_pkg::resolve_t  resolve
);

  import bp_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);

  pc_t        key_q    [BTB_ENTRIES];
  pc_t        target_q [BTB_ENTRIES];
  dir_state_t state_q  [BTB_ENTRIES];
  logic [BTB_ENTRIES-1:0] valid_q;

  logic [IDX_W-1:0] alloc_ptr;
  logic [IDX_W-1:0] alloc_ptr_next;

  logic [BTB_ENTRIES-1:0] lookup_match;
  logic [BTB_ENTRIES-1:0] update_match;
  logic [IDX_W-1:0]       lookup_idx;
  logic [IDX_W-1:0]       update_idx;
  logic                   lookup_hit;
  logic                   update_hit;
  dir_state_t             lookup_state;

  // one step toward the observed outcome, saturating at both ends.
  function automatic dir_state_t step_state(input dir_state_t state, input logic taken);
    dir_state_t next_state;
    case (state)
      strong_taken:     next_state = taken ? strong_taken : weak_taken;
      weak_taken:       next_state = taken ? strong_taken : weak_not_taken;
      weak_not_taken:   next_state = taken ? weak_taken : strong_not_taken;
      strong_not_taken: next_state = taken ? weak_not_taken : strong_not_taken;
      default:          next_state = taken ? strong_taken : strong_not_taken;
    endcase
    return next_state;
  endfunction

  // full-pc compare, any direction state counts as a match.
  always_comb begin
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      lookup_match[i] = lookup_enable && valid_q[i] && (key_q[i] == pc);
      update_match[i] = valid_q[i] && (key_q[i] == resolve.pc);
    end
  end

  priority_encoder #(
    .WIDTH(BTB_ENTRIES)
  ) u_lookup_enc (
    .match_vec(lookup_match),
    .index    (lookup_idx),
    .any_match(lookup_hit)
  );

  priority_encoder #(
    .WIDTH(BTB_ENTRIES)
  ) u_update_enc (
    .match_vec(update_match),
    .index    (update_idx),
    .any_match(update_hit)
  );

  assign lookup_state = state_q[lookup_idx];

  always_comb begin
    lookup.hit           = lookup_hit;
    lookup.predict_taken = lookup_hit &&
                           (lookup_state == strong_taken || lookup_state == weak_taken);
    lookup.target        = target_q[lookup_idx];
  end

  assign alloc_ptr_next = (alloc_ptr == IDX_W'(BTB_ENTRIES - 1)) ? '0 : alloc_ptr + 1'b1;

  // table contents.
  always_ff @(posedge clk) begin
    if (resolve.valid) begin
      if (update_hit) begin
        if (resolve.taken) begin
          target_q[update_idx] <= resolve.target; // keep last taken target.
        end
        state_q[update_idx] <= step_state(state_q[update_idx], resolve.taken);
      end else begin
        key_q[alloc_ptr]    <= resolve.pc;
        target_q[alloc_ptr] <= resolve.target;
        state_q[alloc_ptr]  <= resolve.taken ? strong_taken : strong_not_taken;
      end
    end
  end

  // valid bits and round-robin pointer; flush beats a same-cycle update.
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid_q   <= '0;
      alloc_ptr <= '0;
    end else if (resolve.valid && !update_hit) begin
      valid_q[alloc_ptr] <= 1'b1;
      alloc_ptr          <= alloc_ptr_next;
    end
  end

endmodule

`default_nettype wire

// File: src/priority_encoder.sv
`default_nettype none

module priority_encoder #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]         match_vec,
  output logic [$clog2(WIDTH)-1:0] index,
  output logic                     any_match
);

  // scan downward so the lowest set bit is the last one assigned.
  always_comb begin
    index = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        index = ($clog2(WIDTH))'(i);
      end
    end
  end

  assign any_match = |match_vec;

endmodule

`default_nettype wire

// File: src/bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int CSR_ADDR_WIDTH = 2;

  typedef logic [ADDR_WIDTH-1:0] pc_t;

  // two-bit saturating counter, one-hot.
  typedef enum logic [3:0] {
    strong_taken     = 4'b0001,
    weak_taken       = 4'b0010,
    weak_not_taken   = 4'b0100,
    strong_not_taken = 4'b1000
  } dir_state_t;

  // from execute, one entry per resolved branch.
  typedef struct packed {
    logic valid;    // one-cycle strobe.
    pc_t  pc;       // pc of the branch itself.
    pc_t  target;
    logic taken;
    logic redirect; // mispredict seen in execute.
    pc_t  next_pc;  // correct continuation.
  } resolve_t;

  // answer of the btb for the current fetch pc.
  typedef struct packed {
    logic hit;
    logic predict_taken;
    pc_t  target;
  } lookup_t;

endpackage

`default_nettype wire
